// File: list.f
+incdir+.
mcif_req_pkg.sv
mcif_ctrl_pkg.sv
mcif_burst_if.sv
mcif_rd_burst_split.sv
mcif_rd_arb.sv
mcif_rd_os_ctrl.sv
mcif_rd_ar_out.sv
mcif_rd_ig_top.sv
mcif_rd_ig_tb.sv

// File: mcif_burst_if.sv
//////////////////////////////////////////////////
// Burst channel with valid/ready handshake
// payload held stable while valid waits for ready
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface mcif_burst_if
  import mcif_req_pkg::*;
();

  logic   valid;
  logic   ready;
  burst_t payload;

  modport source (
    output valid,
    output payload,
    input  ready
  );

  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// File: mcif_ctrl_pkg.sv
//////////////////////////////////////////////////
// Control types for splitter, arbiter, os limit
//////////////////////////////////////////////////
`default_nettype none

`include "mcif_rd_consts.svh"

package mcif_ctrl_pkg;

  typedef enum logic {
    IDLE  = 1'b0,
    SPLIT = 1'b1
  } split_state_e;

  typedef logic [`MCIF_OS_W:0] os_cnt_t;  // one bit over, reaches limit + 1

  typedef logic [`MCIF_WEIGHT_W-1:0] weight_t;

endpackage

`default_nettype wire

// File: mcif_rd_ar_out.sv
//////////////////////////////////////////////////
// AXI read address output slot
// one registered beat, refills on the same edge
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mcif_rd_consts.svh"

module mcif_rd_ar_out
  import mcif_req_pkg::*;
(
  input  logic                       nvdla_core_clk,
  input  logic                       rst_n,
  mcif_burst_if.sink                 issue,
  output logic                       ar_arvalid,
  input  logic                       ar_arready,
  output logic [`MCIF_ID_W-1:0]      ar_arid,
  output logic [`MCIF_AXI_LEN_W-1:0] ar_arlen,
  output logic [`MCIF_ADDR_W-1:0]    ar_araddr
);

  burst_t slot;
  logic   full;
  logic   load;

  assign issue.ready = !full || ar_arready;  // empty or draining now
  assign load        = issue.valid && issue.ready;

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (ar_arready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      slot <= issue.payload;
    end
  end

  assign ar_arvalid = full;
  assign ar_arid    = slot.id;
  assign ar_arlen   = `MCIF_AXI_LEN_W'(slot.len);
  assign ar_araddr  = {slot.addr, `MCIF_ATOM_SHIFT'(0)};  // atoms back to bytes

endmodule

`default_nettype wire

// File: mcif_rd_arb.sv
//////////////////////////////////////////////////
// Weighted round-robin over client bursts
// a client keeps the grant for weight+1 beats
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mcif_rd_consts.svh"

module mcif_rd_arb
  import mcif_req_pkg::*, mcif_ctrl_pkg::*;
(
  input  logic          nvdla_core_clk,
  input  logic          rst_n,
  mcif_burst_if.sink    req0,
  mcif_burst_if.sink    req1,
  mcif_burst_if.sink    req2,
  input  weight_t       weight0,
  input  weight_t       weight1,
  input  weight_t       weight2,
  mcif_burst_if.source  grant
);

  localparam int N     = `MCIF_NUM_CLIENTS;
  localparam int PTR_W = $clog2(N);
  localparam int RUN_W = `MCIF_WEIGHT_W + 1;

  logic [N-1:0]     vld;
  burst_t           pl  [N];
  weight_t          wgt [N];
  logic [PTR_W-1:0] ptr;       // client holding the current run
  logic [PTR_W-1:0] sel;
  logic [PTR_W-1:0] cand;
  logic [RUN_W-1:0] run_cnt;   // beats granted in this run
  logic             keep;
  logic             found;
  logic             any_vld;
  logic             fire;

  function automatic logic [PTR_W-1:0] next_idx(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(N - 1)) ? '0 : p + 1'b1;
  endfunction

  assign vld = {req2.valid, req1.valid, req0.valid};
  assign pl[0] = req0.payload;
  assign pl[1] = req1.payload;
  assign pl[2] = req2.payload;
  assign wgt[0] = weight0;
  assign wgt[1] = weight1;
  assign wgt[2] = weight2;

  // stay on ptr or search ptr+1, ptr+2, ptr
  always_comb begin
    keep  = vld[ptr] && (run_cnt <= {1'b0, wgt[ptr]});
    sel   = ptr;
    cand  = ptr;
    found = 1'b0;
    if (!keep) begin
      for (int i = 0; i < N; i++) begin
        cand = next_idx(cand);
        if (vld[cand] && !found) begin
          sel   = cand;
          found = 1'b1;
        end
      end
    end
  end

  assign any_vld       = |vld;
  assign grant.valid   = any_vld;
  assign grant.payload = pl[sel];
  assign fire          = grant.valid && grant.ready;

  assign req0.ready = grant.ready && any_vld && (sel == PTR_W'(0));
  assign req1.ready = grant.ready && any_vld && (sel == PTR_W'(1));
  assign req2.ready = grant.ready && any_vld && (sel == PTR_W'(2));

  // ptr follows sel so a stalled grant stays put
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr     <= '0;
      run_cnt <= '0;
    end else if (any_vld) begin
      ptr     <= sel;
      run_cnt <= (keep ? run_cnt : '0) + RUN_W'(fire);  // new run restarts count
    end
  end

endmodule

`default_nettype wire

// File: mcif_rd_burst_split.sv
//////////////////////////////////////////////////
// Per-client burst splitter
// cuts a request into 4-atom aligned bursts and
// checks return FIFO credits when LAT_DEPTH > 0
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mcif_rd_consts.svh"

module mcif_rd_burst_split
  import mcif_req_pkg::*, mcif_ctrl_pkg::*;
#(
  parameter client_e CLIENT_ID = CLIENT_CDMA_DAT,
  parameter int      LAT_DEPTH = 0
) (
  input  logic          nvdla_core_clk,
  input  logic          rst_n,
  input  logic          req_valid,
  output logic          req_ready,
  input  rd_req_t       req,
  input  logic          lat_fifo_pop,
  mcif_burst_if.source  burst
);

  localparam int ATOM_W = `MCIF_ADDR_W - `MCIF_ATOM_SHIFT;
  localparam int CNT_W  = `MCIF_SIZE_W + 1;
  localparam int NB_W   = `MCIF_LEN_W + 1;

  split_state_e      state;
  logic [ATOM_W-1:0] cur_atom;   // next burst start
  logic [CNT_W-1:0]  left;       // atoms still to issue
  logic [NB_W-1:0]   to_bound;
  logic [NB_W-1:0]   nb;         // atoms in this burst
  logic              credit_ok;
  logic              req_fire;
  logic              burst_fire;

  //////////////////////////////////////////////////
  // burst size
  //////////////////////////////////////////////////
  assign to_bound = NB_W'(`MCIF_MAX_BURST) - {1'b0, cur_atom[`MCIF_LEN_W-1:0]};
  assign nb       = (left < CNT_W'(to_bound)) ? left[NB_W-1:0] : to_bound;

  assign req_ready  = (state == IDLE);
  assign req_fire   = req_valid && req_ready;
  assign burst_fire = burst.valid && burst.ready;

  assign burst.valid        = (state == SPLIT) && credit_ok;
  assign burst.payload.addr = cur_atom;
  assign burst.payload.len  = `MCIF_LEN_W'(nb - 1'b1);
  assign burst.payload.id   = CLIENT_ID;

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else if (req_fire) begin
      state <= SPLIT;
    end else if (burst_fire && (left == CNT_W'(nb))) begin
      state <= IDLE;  // last burst gone
    end
  end

  // held request, walked forward per burst
  always_ff @(posedge nvdla_core_clk) begin
    if (req_fire) begin
      cur_atom <= req.addr[`MCIF_ADDR_W-1:`MCIF_ATOM_SHIFT];
      left     <= CNT_W'(req.size) + 1'b1;
    end else if (burst_fire) begin
      cur_atom <= cur_atom + ATOM_W'(nb);
      left     <= left - CNT_W'(nb);
    end
  end

  //////////////////////////////////////////////////
  // latency FIFO credits
  //////////////////////////////////////////////////
  if (LAT_DEPTH != 0) begin : g_credit
    logic [`MCIF_CREDIT_W-1:0] credit;

    always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
      if (!rst_n) begin
        credit <= `MCIF_CREDIT_W'(LAT_DEPTH);
      end else begin
        credit <= credit + `MCIF_CREDIT_W'(lat_fifo_pop)
                - (burst_fire ? `MCIF_CREDIT_W'(nb) : '0);  // taken at transfer
      end
    end

    assign credit_ok = (credit >= `MCIF_CREDIT_W'(nb));
  end else begin : g_no_credit
    assign credit_ok = 1'b1;  // no return FIFO to protect
  end

endmodule

`default_nettype wire

// File: mcif_rd_consts.svh
//////////////////////////////////////////////////
// MCIF read ingress constants
// widths, burst limits, latency depth, clients
//////////////////////////////////////////////////
`ifndef MCIF_RD_CONSTS_SVH
`define MCIF_RD_CONSTS_SVH

`define MCIF_ADDR_W        32  // byte address
`define MCIF_SIZE_W        8   // request size, atoms minus one
`define MCIF_ATOM_SHIFT    5   // 32-byte atoms
`define MCIF_MAX_BURST     4   // atoms per burst
`define MCIF_LEN_W         2   // burst len, atoms minus one
`define MCIF_ID_W          8
`define MCIF_WEIGHT_W      8
`define MCIF_OS_W          8
`define MCIF_SDP_LAT_DEPTH 16  // sdp return fifo, in atoms
`define MCIF_CREDIT_W      8
`define MCIF_NUM_CLIENTS   3

// derived widths
`define MCIF_ATOM_ADDR_W   (`MCIF_ADDR_W - `MCIF_ATOM_SHIFT)
`define MCIF_AXI_LEN_W     4

`endif

// File: mcif_rd_ig_tb.sv
//////////////////////////////////////////////////
// MCIF read ingress testbench
// directed tests with an AR-side completion model
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mcif_rd_consts.svh"

module mcif_rd_ig_tb
  import mcif_req_pkg::*, mcif_ctrl_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int MAX_BEATS  = 100;                        // all tests together stay below
  localparam int WDOG_NS    = MAX_BEATS * 50 * CLK_PERIOD;  // ~50 cycles per beat

  typedef struct packed {
    logic [`MCIF_ID_W-1:0]      id;
    logic [`MCIF_AXI_LEN_W-1:0] len;
    logic [`MCIF_ADDR_W-1:0]    addr;
  } beat_t;

  logic nvdla_core_clk;
  logic rst_n;
  logic cdma_dat_rd_req_valid, cdma_dat_rd_req_ready;
  logic cdma_wt_rd_req_valid, cdma_wt_rd_req_ready;
  logic sdp_rd_req_valid, sdp_rd_req_ready;
  logic [`MCIF_ADDR_W-1:0] cdma_dat_rd_req_addr, cdma_wt_rd_req_addr, sdp_rd_req_addr;
  logic [`MCIF_SIZE_W-1:0] cdma_dat_rd_req_size, cdma_wt_rd_req_size, sdp_rd_req_size;
  logic sdp_rd_cdt_lat_fifo_pop;
  weight_t reg_rd_weight_cdma_dat, reg_rd_weight_cdma_wt, reg_rd_weight_sdp;
  logic [`MCIF_OS_W-1:0] reg_rd_os_cnt;
  logic eg2ig_axi_vld;
  logic ar_arvalid, ar_arready;
  logic [`MCIF_ID_W-1:0]      ar_arid;
  logic [`MCIF_AXI_LEN_W-1:0] ar_arlen;
  logic [`MCIF_ADDR_W-1:0]    ar_araddr;

  beat_t exp_q[$];          // expected AR beats in order
  int beats_seen     = 0;   // AR transfers
  int sdp_atoms_seen = 0;
  int cmpl_sent      = 0;
  int pops_sent      = 0;
  int cmpl_manual    = 0;
  int pop_manual     = 0;
  bit auto_cmpl      = 1;   // completion per AR beat
  bit auto_pop       = 1;   // sdp credit back per atom

  mcif_rd_ig_top dut_i (
    .nvdla_core_clk          (nvdla_core_clk),
    .rst_n                   (rst_n),
    .cdma_dat_rd_req_valid   (cdma_dat_rd_req_valid),
    .cdma_dat_rd_req_ready   (cdma_dat_rd_req_ready),
    .cdma_dat_rd_req_addr    (cdma_dat_rd_req_addr),
    .cdma_dat_rd_req_size    (cdma_dat_rd_req_size),
    .cdma_wt_rd_req_valid    (cdma_wt_rd_req_valid),
    .cdma_wt_rd_req_ready    (cdma_wt_rd_req_ready),
    .cdma_wt_rd_req_addr     (cdma_wt_rd_req_addr),
    .cdma_wt_rd_req_size     (cdma_wt_rd_req_size),
    .sdp_rd_req_valid        (sdp_rd_req_valid),
    .sdp_rd_req_ready        (sdp_rd_req_ready),
    .sdp_rd_req_addr         (sdp_rd_req_addr),
    .sdp_rd_req_size         (sdp_rd_req_size),
    .sdp_rd_cdt_lat_fifo_pop (sdp_rd_cdt_lat_fifo_pop),
    .reg_rd_weight_cdma_dat  (reg_rd_weight_cdma_dat),
    .reg_rd_weight_cdma_wt   (reg_rd_weight_cdma_wt),
    .reg_rd_weight_sdp       (reg_rd_weight_sdp),
    .reg_rd_os_cnt           (reg_rd_os_cnt),
    .eg2ig_axi_vld           (eg2ig_axi_vld),
    .ar_arvalid              (ar_arvalid),
    .ar_arready              (ar_arready),
    .ar_arid                 (ar_arid),
    .ar_arlen                (ar_arlen),
    .ar_araddr               (ar_araddr)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(CLK_PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // memory side model with AR monitor and credits
  //////////////////////////////////////////////////
  always @(posedge nvdla_core_clk) begin
    beat_t exp;
    if (rst_n && ar_arvalid && ar_arready) begin
      assert (exp_q.size() > 0)
        else abort_run($sformatf("Unexpected AR beat at %0t ns with address %h", $time, ar_araddr));
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
        assert ({ar_arid, ar_arlen, ar_araddr} == exp)
          else abort_run($sformatf("Fail at %0t ns: AR id/len/addr %0d/%0d/%h, expected %0d/%0d/%h",
                                   $time, ar_arid, ar_arlen, ar_araddr, exp.id, exp.len, exp.addr));
      end
      beats_seen++;
      if (ar_arid == CLIENT_SDP) sdp_atoms_seen += ar_arlen + 1;
    end
  end

  always @(negedge nvdla_core_clk) begin
    if (rst_n && cmpl_sent < (auto_cmpl ? beats_seen : cmpl_manual)) begin
      eg2ig_axi_vld = 1'b1;
      cmpl_sent++;
    end else begin
      eg2ig_axi_vld = 1'b0;
    end
    if (rst_n && pops_sent < (auto_pop ? sdp_atoms_seen : pop_manual)) begin
      sdp_rd_cdt_lat_fifo_pop = 1'b1;  // one atom per cycle
      pops_sent++;
    end else begin
      sdp_rd_cdt_lat_fifo_pop = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  // reference split up to the next 4-atom boundary then full bursts
  task automatic split_model(input client_e id, input logic [31:0] addr, input logic [7:0] size);
    logic [`MCIF_ATOM_ADDR_W-1:0] atom;
    int left;
    int nb;
    beat_t b;
    atom = addr >> `MCIF_ATOM_SHIFT;
    left = size + 1;
    while (left > 0) begin
      nb = `MCIF_MAX_BURST - (atom % `MCIF_MAX_BURST);
      if (left < nb) nb = left;
      b.id   = id;
      b.len  = nb - 1;
      b.addr = {atom, {`MCIF_ATOM_SHIFT{1'b0}}};
      exp_q.push_back(b);
      atom = atom + nb;
      left = left - nb;
    end
  endtask

  task automatic set_req(input client_e id, input logic v, input logic [31:0] a,
                         input logic [7:0] s);
    case (id)
      CLIENT_CDMA_DAT: {cdma_dat_rd_req_valid, cdma_dat_rd_req_addr, cdma_dat_rd_req_size} = {v, a, s};
      CLIENT_CDMA_WT:  {cdma_wt_rd_req_valid, cdma_wt_rd_req_addr, cdma_wt_rd_req_size} = {v, a, s};
      default:         {sdp_rd_req_valid, sdp_rd_req_addr, sdp_rd_req_size} = {v, a, s};
    endcase
  endtask

  function automatic logic ready_of(input client_e id);
    case (id)
      CLIENT_CDMA_DAT: return cdma_dat_rd_req_ready;
      CLIENT_CDMA_WT:  return cdma_wt_rd_req_ready;
      default:         return sdp_rd_req_ready;
    endcase
  endfunction

  task automatic send_req(input client_e id, input logic [31:0] addr, input logic [7:0] size);
    int n;
    n = 0;
    @(negedge nvdla_core_clk);
    while (!ready_of(id)) begin
      @(negedge nvdla_core_clk);
      n++;
      assert (n < 400) else abort_run("A client request was never accepted");
    end
    set_req(id, 1'b1, addr, size);
    @(negedge nvdla_core_clk);
    set_req(id, 1'b0, '0, '0);
  endtask

  task automatic wait_beats(input int target, input int max_cycles);
    int n;
    n = 0;
    while (beats_seen < target) begin
      @(negedge nvdla_core_clk);
      n++;
      assert (n <= max_cycles)
        else abort_run($sformatf("AR beat %0d did not arrive within %0d cycles", target, max_cycles));
    end
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 || cmpl_sent != beats_seen || ar_arvalid
           || (auto_pop && pops_sent != sdp_atoms_seen)) begin
      @(negedge nvdla_core_clk);
      n++;
      assert (n <= max_cycles)
        else abort_run($sformatf("Traffic stalled with %0d AR beats still expected", exp_q.size()));
    end
  endtask

  task automatic apply_reset();
    @(negedge nvdla_core_clk);
    rst_n = 1'b0;
    repeat (2) @(negedge nvdla_core_clk);
    rst_n = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic reset_value_test();
    @(negedge nvdla_core_clk);
    assert (!ar_arvalid && cdma_dat_rd_req_ready && cdma_wt_rd_req_ready && sdp_rd_req_ready)
      else abort_run($sformatf("Fail at %0t ns: arvalid %b, readies %b%b%b after reset", $time,
                               ar_arvalid, cdma_dat_rd_req_ready, cdma_wt_rd_req_ready,
                               sdp_rd_req_ready));
  endtask

  task automatic burst_split_test();
    logic [31:0] addr;
    logic [7:0]  size;
    for (int i = 0; i < 10; i++) begin
      addr = $urandom;
      size = $urandom_range(15, 0);  // 1 to 16 atoms
      split_model(CLIENT_CDMA_DAT, addr, size);
      send_req(CLIENT_CDMA_DAT, addr, size);
    end
    wait_drained(500);
  endtask

  task automatic weighting_test();
    beat_t q0[$];
    beat_t q1[$];
    beat_t q2[$];
    beat_t b;
    apply_reset();  // arbiter pointer back to client 0
    split_model(CLIENT_CDMA_DAT, 32'h0000_1000, 8'd47);
    split_model(CLIENT_CDMA_WT, 32'h0000_2000, 8'd15);
    split_model(CLIENT_SDP, 32'h0000_3000, 8'd31);
    while (exp_q.size() > 0) begin
      b = exp_q.pop_front();
      if (b.id == CLIENT_CDMA_DAT) q0.push_back(b);
      else if (b.id == CLIENT_CDMA_WT) q1.push_back(b);
      else q2.push_back(b);
    end
    // weight+1 beats per client, turn order 0, 1, 2
    while (q0.size() + q1.size() + q2.size() > 0) begin
      for (int k = 0; k <= int'(reg_rd_weight_cdma_dat) && q0.size() > 0; k++)
        exp_q.push_back(q0.pop_front());
      for (int k = 0; k <= int'(reg_rd_weight_cdma_wt) && q1.size() > 0; k++)
        exp_q.push_back(q1.pop_front());
      for (int k = 0; k <= int'(reg_rd_weight_sdp) && q2.size() > 0; k++)
        exp_q.push_back(q2.pop_front());
    end
    @(negedge nvdla_core_clk);
    set_req(CLIENT_CDMA_DAT, 1'b1, 32'h0000_1000, 8'd47);
    set_req(CLIENT_CDMA_WT, 1'b1, 32'h0000_2000, 8'd15);
    set_req(CLIENT_SDP, 1'b1, 32'h0000_3000, 8'd31);
    @(negedge nvdla_core_clk);
    set_req(CLIENT_CDMA_DAT, 1'b0, '0, '0);
    set_req(CLIENT_CDMA_WT, 1'b0, '0, '0);
    set_req(CLIENT_SDP, 1'b0, '0, '0);
    wait_drained(400);
  endtask

  task automatic credit_limit_test();
    int base_beats;
    int base_atoms;
    apply_reset();
    @(posedge nvdla_core_clk);
    auto_pop   = 1'b0;
    pop_manual = pops_sent;
    base_beats = beats_seen;
    base_atoms = sdp_atoms_seen;
    split_model(CLIENT_SDP, 32'h0001_0000, 8'd19);
    send_req(CLIENT_SDP, 32'h0001_0000, 8'd19);
    wait_beats(base_beats + 4, 100);
    repeat (50) begin
      @(negedge nvdla_core_clk);
      assert (!ar_arvalid)
        else abort_run($sformatf("Fail at %0t ns: sdp burst issued with no credit", $time));
    end
    assert (sdp_atoms_seen - base_atoms == `MCIF_SDP_LAT_DEPTH)
      else abort_run($sformatf("Fail at %0t ns: %0d sdp atoms before credit ran out", $time,
                               sdp_atoms_seen - base_atoms));
    @(posedge nvdla_core_clk);
    pop_manual = pops_sent + 4;
    wait_drained(100);
    @(posedge nvdla_core_clk);
    auto_pop = 1'b1;  // hand the rest of the credit back
    wait_drained(100);
  endtask

  task automatic outstanding_test();
    int base_beats;
    int stall;
    beat_t held;
    apply_reset();
    reg_rd_os_cnt = 8'd1;
    @(posedge nvdla_core_clk);
    auto_cmpl   = 1'b0;
    cmpl_manual = cmpl_sent;
    base_beats  = beats_seen;
    split_model(CLIENT_CDMA_DAT, 32'h0000_4000, 8'd19);
    send_req(CLIENT_CDMA_DAT, 32'h0000_4000, 8'd19);
    wait_beats(base_beats + 2, 50);
    repeat (30) @(negedge nvdla_core_clk);
    assert (beats_seen == base_beats + 2)
      else abort_run($sformatf("Fail at %0t ns: %0d AR beats in flight, limit is 2", $time,
                               beats_seen - base_beats));
    ar_arready = 1'b0;
    @(posedge nvdla_core_clk);
    cmpl_manual = cmpl_sent + 1;  // one slot frees up
    while (!ar_arvalid) @(negedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    held  = {ar_arid, ar_arlen, ar_araddr};
    stall = $urandom_range(20, 5);
    repeat (stall) begin
      @(negedge nvdla_core_clk);
      assert (ar_arvalid && {ar_arid, ar_arlen, ar_araddr} == held)
        else abort_run($sformatf("Fail at %0t ns: AR beat changed under back-pressure", $time));
    end
    ar_arready = 1'b1;
    @(posedge nvdla_core_clk);
    auto_cmpl = 1'b1;
    wait_drained(200);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(29417));
    rst_n = 1'b0;
    set_req(CLIENT_CDMA_DAT, 1'b0, '0, '0);
    set_req(CLIENT_CDMA_WT, 1'b0, '0, '0);
    set_req(CLIENT_SDP, 1'b0, '0, '0);
    sdp_rd_cdt_lat_fifo_pop = 1'b0;
    eg2ig_axi_vld           = 1'b0;
    reg_rd_weight_cdma_dat  = 8'd2;
    reg_rd_weight_cdma_wt   = 8'd0;
    reg_rd_weight_sdp       = 8'd1;
    reg_rd_os_cnt           = 8'hff;  // effectively no limit
    ar_arready              = 1'b1;
    apply_reset();
    reset_value_test();
    burst_split_test();
    weighting_test();
    credit_limit_test();
    outstanding_test();
    $display("=== PASS ===");
    $finish;
  end

  initial begin
    #(WDOG_NS);
    abort_run("Timeout: the tests did not finish in the expected time");
  end

endmodule

`default_nettype wire

// File: mcif_rd_ig_top.sv
//////////////////////////////////////////////////
// MCIF read ingress top
// splitters, WRR arbiter, os limit, AR slot
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mcif_rd_consts.svh"

module mcif_rd_ig_top
  import mcif_req_pkg::*, mcif_ctrl_pkg::*;
(
  input  logic                       nvdla_core_clk,
  input  logic                       rst_n,
  input  logic                       cdma_dat_rd_req_valid,
  output logic                       cdma_dat_rd_req_ready,
  input  logic [`MCIF_ADDR_W-1:0]    cdma_dat_rd_req_addr,
  input  logic [`MCIF_SIZE_W-1:0]    cdma_dat_rd_req_size,
  input  logic                       cdma_wt_rd_req_valid,
  output logic                       cdma_wt_rd_req_ready,
  input  logic [`MCIF_ADDR_W-1:0]    cdma_wt_rd_req_addr,
  input  logic [`MCIF_SIZE_W-1:0]    cdma_wt_rd_req_size,
  input  logic                       sdp_rd_req_valid,
  output logic                       sdp_rd_req_ready,
  input  logic [`MCIF_ADDR_W-1:0]    sdp_rd_req_addr,
  input  logic [`MCIF_SIZE_W-1:0]    sdp_rd_req_size,
  input  logic                       sdp_rd_cdt_lat_fifo_pop,
  input  weight_t                    reg_rd_weight_cdma_dat,
  input  weight_t                    reg_rd_weight_cdma_wt,
  input  weight_t                    reg_rd_weight_sdp,
  input  logic [`MCIF_OS_W-1:0]      reg_rd_os_cnt,
  input  logic                       eg2ig_axi_vld,
  output logic                       ar_arvalid,
  input  logic                       ar_arready,
  output logic [`MCIF_ID_W-1:0]      ar_arid,
  output logic [`MCIF_AXI_LEN_W-1:0] ar_arlen,
  output logic [`MCIF_ADDR_W-1:0]    ar_araddr
);

  rd_req_t dat_req;
  rd_req_t wt_req;
  rd_req_t sdp_req;

  assign dat_req = '{addr: cdma_dat_rd_req_addr, size: cdma_dat_rd_req_size};
  assign wt_req  = '{addr: cdma_wt_rd_req_addr, size: cdma_wt_rd_req_size};
  assign sdp_req = '{addr: sdp_rd_req_addr, size: sdp_rd_req_size};

  mcif_burst_if split_if [`MCIF_NUM_CLIENTS] ();
  mcif_burst_if arb_if ();
  mcif_burst_if ar_if ();

  //////////////////////////////////////////////////
  // per-client splitters
  //////////////////////////////////////////////////
  mcif_rd_burst_split #(.CLIENT_ID(CLIENT_CDMA_DAT), .LAT_DEPTH(0)) u_split_dat (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .req_valid      (cdma_dat_rd_req_valid),
    .req_ready      (cdma_dat_rd_req_ready),
    .req            (dat_req),
    .lat_fifo_pop   (1'b0),            // cdma has no latency fifo
    .burst          (split_if[0])
  );

  mcif_rd_burst_split #(.CLIENT_ID(CLIENT_CDMA_WT), .LAT_DEPTH(0)) u_split_wt (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .req_valid      (cdma_wt_rd_req_valid),
    .req_ready      (cdma_wt_rd_req_ready),
    .req            (wt_req),
    .lat_fifo_pop   (1'b0),
    .burst          (split_if[1])
  );

  mcif_rd_burst_split #(
    .CLIENT_ID (CLIENT_SDP),
    .LAT_DEPTH (`MCIF_SDP_LAT_DEPTH)
  ) u_split_sdp (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .req_valid      (sdp_rd_req_valid),
    .req_ready      (sdp_rd_req_ready),
    .req            (sdp_req),
    .lat_fifo_pop   (sdp_rd_cdt_lat_fifo_pop),
    .burst          (split_if[2])
  );

  //////////////////////////////////////////////////
  // arbitration and issue
  //////////////////////////////////////////////////
  mcif_rd_arb u_arb (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .req0           (split_if[0]),
    .req1           (split_if[1]),
    .req2           (split_if[2]),
    .weight0        (reg_rd_weight_cdma_dat),
    .weight1        (reg_rd_weight_cdma_wt),
    .weight2        (reg_rd_weight_sdp),
    .grant          (arb_if)
  );

  mcif_rd_os_ctrl u_os_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .reg_rd_os_cnt  (reg_rd_os_cnt),
    .eg2ig_axi_vld  (eg2ig_axi_vld),
    .arb            (arb_if),
    .issue          (ar_if)
  );

  mcif_rd_ar_out u_ar_out (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .issue          (ar_if),
    .ar_arvalid     (ar_arvalid),
    .ar_arready     (ar_arready),
    .ar_arid        (ar_arid),
    .ar_arlen       (ar_arlen),
    .ar_araddr      (ar_araddr)
  );

endmodule

`default_nettype wire

// File: mcif_rd_os_ctrl.sv
//////////////////////////////////////////////////
// Outstanding burst limiter
// allows up to reg_rd_os_cnt+1 bursts in flight
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mcif_rd_consts.svh"

module mcif_rd_os_ctrl
  import mcif_ctrl_pkg::*;
(
  input  logic                  nvdla_core_clk,
  input  logic                  rst_n,
  input  logic [`MCIF_OS_W-1:0] reg_rd_os_cnt,
  input  logic                  eg2ig_axi_vld,  // one burst completed
  mcif_burst_if.sink            arb,
  mcif_burst_if.source          issue
);

  os_cnt_t os_cnt;
  logic    allow;
  logic    issue_fire;

  assign allow      = (os_cnt <= {1'b0, reg_rd_os_cnt});
  assign issue_fire = issue.valid && issue.ready;

  assign issue.valid   = arb.valid && allow;
  assign issue.payload = arb.payload;
  assign arb.ready     = issue.ready && allow;

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      os_cnt <= '0;
    end else begin
      case ({issue_fire, eg2ig_axi_vld})
        2'b10:   os_cnt <= os_cnt + 1'b1;
        2'b01:   os_cnt <= os_cnt - 1'b1;
        default: os_cnt <= os_cnt;  // both or neither cancel out
      endcase
    end
  end

endmodule

`default_nettype wire

// File: mcif_req_pkg.sv
//////////////////////////////////////////////////
// Request and burst payload types
// client ids match the AXI arid values
//////////////////////////////////////////////////
`default_nettype none

`include "mcif_rd_consts.svh"

package mcif_req_pkg;

  typedef enum logic [`MCIF_ID_W-1:0] {
    CLIENT_CDMA_DAT = 0,
    CLIENT_CDMA_WT  = 1,
    CLIENT_SDP      = 2
  } client_e;

  // request as seen on a client port
  typedef struct packed {
    logic [`MCIF_ADDR_W-1:0] addr;  // byte address, low bits ignored
    logic [`MCIF_SIZE_W-1:0] size;  // atoms minus one
  } rd_req_t;

  // one aligned burst, address in atoms
  typedef struct packed {
    logic [`MCIF_ATOM_ADDR_W-1:0] addr;
    logic [`MCIF_LEN_W-1:0]       len;   // atoms minus one
    client_e                      id;
  } burst_t;

endpackage

`default_nettype wire
